// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0 -Wno-fatal
TOP       := tb_cnn
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cnn_conv.sv
`timescale 1ns/10ps

module cnn_conv import cnn_pkg::*; #(
    parameter int PIX_W = cnn_pkg::PIX_W,
    parameter int ACC_W = cnn_pkg::ACC_W
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       pad_replicate,
    input  pix_t       img_data,
    input  pix_t       ker_data,
    output logic [5:0] img_addr,
    output logic [4:0] ker_addr,
    output conv_out_t  conv_out
);

    logic       busy;
    // spacer cycle after each position's last product
    logic       gap;
    logic [3:0] pos;
    logic [1:0] ch;
    logic [1:0] kr;
    logic [1:0] kc;
    logic [2:0] row_map;
    logic [2:0] col_map;
    logic       tap_out;
    logic       last_tap;

    logic signed [2*PIX_W-1:0] prod;
    logic signed [2*PIX_W-1:0] prod_m;
    logic signed [ACC_W-1:0]   acc;
    logic signed [ACC_W-1:0]   acc_nxt;

    logic                      sum_vld;
    logic [3:0]                sum_pos;
    logic signed [ACC_W-1:0]   sum_q;

    // base + k - 1 against the image edge
    // returns {outside, clamped index}
    function automatic logic [2:0] edge_map(input logic [1:0] base, input logic [1:0] k);
        logic [2:0] ext;
        logic [2:0] sub;
        logic [2:0] res;
        ext = 3'(base) + 3'(k);
        sub = ext - 3'd1;
        if (ext == 3'd0) begin
            res = {1'b1, 2'd0};
        end else if (ext > 3'(IMG_DIM)) begin
            res = {1'b1, 2'(IMG_DIM - 1)};
        end else begin
            res = {1'b0, sub[1:0]};
        end
        return res;
    endfunction

    // ==================================================
    // address generation and one multiply
    // ==================================================

    assign row_map  = edge_map(pos[3:2], kr);
    assign col_map  = edge_map(pos[1:0], kc);
    assign tap_out  = row_map[2] | col_map[2];
    assign img_addr = {ch, row_map[1:0], col_map[1:0]};
    assign ker_addr = 5'(ch) * 5'(K_DIM * K_DIM) + 5'(kr) * 5'(K_DIM) + 5'(kc);

    assign last_tap = (ch == 2'(N_CH - 1)) && (kr == 2'(K_DIM - 1)) && (kc == 2'(K_DIM - 1));

    assign prod = img_data * ker_data;

    always_comb begin
        prod_m = prod;
        // zero padding drops taps outside the image, replicate keeps the clamped pixel
        if (tap_out && !pad_replicate) begin
            prod_m = '0;
        end
        acc_nxt = acc + prod_m;
    end

    // ==================================================
    // position / channel / tap sequencing
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            gap     <= 1'b0;
            pos     <= '0;
            ch      <= '0;
            kr      <= '0;
            kc      <= '0;
            sum_vld <= 1'b0;
        end else begin
            sum_vld <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                gap  <= 1'b0;
                pos  <= '0;
                ch   <= '0;
                kr   <= '0;
                kc   <= '0;
            end else if (busy) begin
                if (gap) begin
                    gap <= 1'b0;
                    if (pos == 4'(IMG_DIM * IMG_DIM - 1)) begin
                        busy <= 1'b0;
                    end else begin
                        pos <= pos + 4'd1;
                    end
                end else if (last_tap) begin
                    sum_vld <= 1'b1;
                    gap     <= 1'b1;
                    ch      <= '0;
                    kr      <= '0;
                    kc      <= '0;
                end else if (kc != 2'(K_DIM - 1)) begin
                    kc <= kc + 2'd1;
                end else if (kr != 2'(K_DIM - 1)) begin
                    kc <= '0;
                    kr <= kr + 2'd1;
                end else begin
                    kc <= '0;
                    kr <= '0;
                    ch <= ch + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (busy && !gap) begin
            if (last_tap) begin
                sum_q   <= acc_nxt;
                sum_pos <= pos;
                acc     <= '0;
            end else begin
                acc <= acc_nxt;
            end
        end
    end

    always_comb begin
        conv_out.valid = sum_vld;
        conv_out.pos   = sum_pos;
        conv_out.sum   = sum_q;
    end

endmodule

// File: cnn_loader.sv
`timescale 1ns/10ps

module cnn_loader import cnn_pkg::*; #(
    parameter int PIX_W = cnn_pkg::PIX_W
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  in_beat_t    in_beat,
    input  logic [5:0]  img_addr,
    input  logic [4:0]  ker_addr,
    output pix_t        img_data,
    output pix_t        ker_data,
    output weight_set_t weights,
    output logic        pad_replicate,
    output logic        start
);

    localparam int IMG_WORDS = N_CH * IMG_DIM * IMG_DIM;
    localparam int KER_WORDS = N_CH * K_DIM * K_DIM;

    logic [5:0] beat_cnt;
    logic       last_beat;

    // channel c pixel p sits at c*16 + p, kernel tap t of channel c at c*9 + t
    logic signed [PIX_W-1:0] img_mem [IMG_WORDS];
    logic signed [PIX_W-1:0] ker_mem [KER_WORDS];

    assign last_beat = in_valid && (beat_cnt == 6'(N_BEATS - 1));

    // ==================================================
    // beat counter, opt latch, start pulse
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt      <= '0;
            pad_replicate <= 1'b0;
            start         <= 1'b0;
        end else begin
            // one cycle after the 48th beat lands in storage
            start <= last_beat;
            if (in_valid) begin
                if (last_beat) begin
                    beat_cnt <= '0;
                end else begin
                    beat_cnt <= beat_cnt + 6'd1;
                end
                if (beat_cnt == '0) begin
                    pad_replicate <= in_beat.opt;
                end
            end
        end
    end

    // ==================================================
    // frame storage
    // ==================================================

    always_ff @(posedge clk) begin
        if (in_valid) begin
            img_mem[beat_cnt] <= in_beat.img;
            if (beat_cnt < 6'(KER_WORDS)) begin
                ker_mem[beat_cnt[4:0]] <= in_beat.kernel;
            end
            // weights ride on the first four beats
            if (beat_cnt < 6'd4) begin
                case (beat_cnt[1:0])
                    2'd0:    weights.w0 <= in_beat.weight;
                    2'd1:    weights.w1 <= in_beat.weight;
                    2'd2:    weights.w2 <= in_beat.weight;
                    default: weights.w3 <= in_beat.weight;
                endcase
            end
        end
    end

    // read ports for the conv engine, no latency
    assign img_data = img_mem[img_addr];
    assign ker_data = ker_mem[ker_addr];

endmodule

// File: cnn_pkg.sv
package cnn_pkg;

    // ==================================================
    // data widths
    // ==================================================

    // pixel, kernel tap and fc weight
    localparam int PIX_W = 8;
    // one convolution sum over 27 products
    localparam int ACC_W = 24;
    // one fully-connected result
    localparam int OUT_W = 34;

    // ==================================================
    // frame geometry
    // ==================================================

    localparam int IMG_DIM = 4;
    localparam int N_CH    = 3;
    localparam int K_DIM   = 3;
    localparam int N_BEATS = 48;

    typedef logic signed [PIX_W-1:0] pix_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic signed [OUT_W-1:0] res_t;

    // one input beat, opt only matters on beat 0
    typedef struct packed {
        pix_t img;
        pix_t kernel;
        pix_t weight;
        logic opt;
    } in_beat_t;

    typedef struct packed {
        pix_t w0;
        pix_t w1;
        pix_t w2;
        pix_t w3;
    } weight_set_t;

    // pos is row-major in the 4x4 map
    typedef struct packed {
        logic       valid;
        logic [3:0] pos;
        acc_t       sum;
    } conv_out_t;

endpackage

// File: cnn_pool_fc.sv
`timescale 1ns/10ps

module cnn_pool_fc import cnn_pkg::*; #(
    parameter int PIX_W = cnn_pkg::PIX_W,
    parameter int ACC_W = cnn_pkg::ACC_W,
    parameter int OUT_W = cnn_pkg::OUT_W
) (
    input  logic        clk,
    input  logic        rst_n,
    input  conv_out_t   conv_out,
    input  weight_set_t weights,
    output logic        out_valid,
    output res_t        out_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MAC,
        ST_OUT
    } state_t;

    state_t     state;
    // mac step in ST_MAC, next output index in ST_OUT
    logic [2:0] step;
    logic [1:0] quad;
    logic       quad_first;
    logic       last_pos;

    logic signed [ACC_W-1:0]       mx [4];
    logic [1:0]                    fc_sel;
    logic                          term;
    logic signed [ACC_W-1:0]       mac_m;
    logic signed [PIX_W-1:0]       mac_w;
    logic signed [ACC_W+PIX_W-1:0] mac_prod;
    logic signed [OUT_W-1:0]       fc [4];
    logic signed [OUT_W-1:0]       fc_base;
    logic signed [OUT_W-1:0]       fc_nxt;

    // ==================================================
    // 2x2 max pooling on the fly
    // ==================================================

    // quadrant from row bit 1 and col bit 1
    assign quad       = {conv_out.pos[3], conv_out.pos[1]};
    assign quad_first = !conv_out.pos[2] && !conv_out.pos[0];
    assign last_pos   = conv_out.valid && (conv_out.pos == 4'(IMG_DIM * IMG_DIM - 1));

    always_ff @(posedge clk) begin
        if (conv_out.valid) begin
            if (quad_first || (conv_out.sum > mx[quad])) begin
                mx[quad] <= conv_out.sum;
            end
        end
    end

    // ==================================================
    // fully connected, step = {fc index, term}
    // ==================================================

    assign fc_sel = step[2:1];
    assign term   = step[0];

    // fc0/fc1 use m0,m1 and fc2/fc3 use m2,m3
    assign mac_m = mx[{fc_sel[1], term}];

    always_comb begin
        case ({term, fc_sel[0]})
            2'd0:    mac_w = weights.w0;
            2'd1:    mac_w = weights.w1;
            2'd2:    mac_w = weights.w2;
            default: mac_w = weights.w3;
        endcase
        mac_prod = mac_m * mac_w;
        fc_base  = fc[fc_sel];
        if (!term) begin
            fc_base = '0;
        end
        fc_nxt = fc_base + mac_prod;
    end

    always_ff @(posedge clk) begin
        if (state == ST_MAC) begin
            fc[fc_sel] <= fc_nxt;
        end
    end

    // ==================================================
    // sequencing and output stream
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            step      <= '0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (last_pos) begin
                        state <= ST_MAC;
                        step  <= '0;
                    end
                end
                ST_MAC: begin
                    step <= step + 3'd1;
                    if (step == 3'd7) begin
                        // fc0 is final since step 1
                        state     <= ST_OUT;
                        out_valid <= 1'b1;
                        out_data  <= fc[0];
                        step      <= 3'd1;
                    end
                end
                ST_OUT: begin
                    if (step == 3'd4) begin
                        state     <= ST_IDLE;
                        out_valid <= 1'b0;
                        out_data  <= '0;
                    end else begin
                        out_data <= fc[step[1:0]];
                        step     <= step + 3'd1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: cnn_top.sv
`timescale 1ns/10ps

module cnn_top import cnn_pkg::*; #(
    parameter int PIX_W = cnn_pkg::PIX_W,
    parameter int ACC_W = cnn_pkg::ACC_W,
    parameter int OUT_W = cnn_pkg::OUT_W
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  in_beat_t in_beat,
    output logic     out_valid,
    output res_t     out_data
);

    // loader read ports, addressed by the conv engine
    logic [5:0]  img_addr;
    logic [4:0]  ker_addr;
    pix_t        img_data;
    pix_t        ker_data;

    logic        pad_replicate;
    logic        start;
    weight_set_t weights;
    conv_out_t   conv_out;

    // ==================================================
    // stage chain
    // ==================================================

    cnn_loader #(
        .PIX_W(PIX_W)
    ) i_loader (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_beat      (in_beat),
        .img_addr     (img_addr),
        .ker_addr     (ker_addr),
        .img_data     (img_data),
        .ker_data     (ker_data),
        .weights      (weights),
        .pad_replicate(pad_replicate),
        .start        (start)
    );

    cnn_conv #(
        .PIX_W(PIX_W),
        .ACC_W(ACC_W)
    ) i_conv (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .pad_replicate(pad_replicate),
        .img_data     (img_data),
        .ker_data     (ker_data),
        .img_addr     (img_addr),
        .ker_addr     (ker_addr),
        .conv_out     (conv_out)
    );

    cnn_pool_fc #(
        .PIX_W(PIX_W),
        .ACC_W(ACC_W),
        .OUT_W(OUT_W)
    ) i_pool_fc (
        .clk      (clk),
        .rst_n    (rst_n),
        .conv_out (conv_out),
        .weights  (weights),
        .out_valid(out_valid),
        .out_data (out_data)
    );

endmodule

// File: sim.f
cnn_pkg.sv
cnn_loader.sv
cnn_conv.sv
cnn_pool_fc.sv
cnn_top.sv
tb_clkgen.sv
tb_checker.sv
tb_cnn.sv

// File: tb_checker.sv
`timescale 1ns/10ps

module tb_checker import cnn_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       out_valid,
    input  res_t       out_data,
    input  logic       arm,
    input  int         test_id,
    input  res_t [3:0] exp_vals,
    output int         n_done,
    output int         n_err
);

    logic active;
    int   idx;
    int   test_err;
    int   errs;

    // ==================================================
    // result stream compare
    // ==================================================

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   = 1'b0;
            idx      = 0;
            test_err = 0;
            n_done   <= 0;
            n_err    <= 0;
        end else begin
            errs = 0;
            if (arm) begin
                active   = 1'b1;
                idx      = 0;
                test_err = 0;
            end
            if (out_valid && !active) begin
                $display("%0t: out_valid high while no result was expected", $time);
                errs++;
            end else if (out_valid) begin
                if (out_data !== exp_vals[idx]) begin
                    $display("[ERROR] %0t: out_data (test %0d, result %0d) got %0d, expected %0d",
                             $time, test_id, idx, out_data, $signed(exp_vals[idx]));
                    errs++;
                end
                idx++;
            end else if (active && idx > 0) begin
                // the four results come on consecutive cycles
                $display("%0t: test %0d: out_valid fell after %0d of 4 results",
                         $time, test_id, idx);
                errs++;
                active = 1'b0;
            end
            test_err += errs;
            if (active && idx == 4) begin
                if (test_err == 0) begin
                    $display("test %0d: all 4 results match", test_id);
                end else begin
                    $display("test %0d: %0d errors", test_id, test_err);
                end
                active = 1'b0;
                n_done <= n_done + 1;
            end
            n_err <= n_err + errs;
        end
    end

endmodule

// File: tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen #(
    parameter real PERIOD     = 8.0,
    parameter int  RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // reset held low over the first rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: tb_cnn.sv
`timescale 1ns/10ps

module tb_cnn
    import cnn_pkg::*;
();

    localparam int N_ROWS  = 9;
    localparam int TIMEOUT = 1000;

    typedef enum logic [1:0] {
        FILL_CONST,
        FILL_RAMP,
        FILL_LFSR,
        FILL_EXTREME
    } fill_t;

    // exp_res is filled in by the reference model
    typedef struct packed {
        logic        opt;
        fill_t       fill;
        pix_t        img_val;
        pix_t        ker_val;
        weight_set_t w;
        res_t [3:0]  exp_res;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    in_beat_t    in_beat;
    logic        out_valid;
    res_t        out_data;
    logic        arm;
    int          test_id;
    res_t [3:0]  exp_vals;
    int          n_done;
    int          n_err;

    row_t        rows [N_ROWS];
    pix_t        img_v [N_BEATS];
    pix_t        ker_v [27];
    pix_t        w_v [4];
    logic [31:0] lfsr_state;
    logic        timed_out;
    int          cyc;

    tb_clkgen i_clkgen (
        .clk  (clk),
        .rst_n(rst_n)
    );

    cnn_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_beat  (in_beat),
        .out_valid(out_valid),
        .out_data (out_data)
    );

    tb_checker i_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .out_valid(out_valid),
        .out_data (out_data),
        .arm      (arm),
        .test_id  (test_id),
        .exp_vals (exp_vals),
        .n_done   (n_done),
        .n_err    (n_err)
    );

    // ==================================================
    // random source
    // ==================================================

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic pix_t rand_bits(input int n);
        pix_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // full-range byte or one of the two signed extremes
    function automatic pix_t rand_pix(input fill_t fill);
        if (fill == FILL_LFSR) begin
            return rand_bits(8);
        end
        return (rand_bits(1) != 0) ? 8'h7f : 8'h80;
    endfunction

    // ==================================================
    // frame build and reference model
    // ==================================================

    task automatic build_frame(input int r);
        int rr;
        int cc;
        for (int k = 0; k < N_BEATS; k++) begin
            rr = (k % 16) / 4;
            cc = k % 4;
            if (rows[r].fill == FILL_CONST) begin
                img_v[k] = rows[r].img_val;
            end else if (rows[r].fill == FILL_RAMP) begin
                // bowl plus a small ramp so each quadrant peaks at its outer corner
                img_v[k] = pix_t'(rows[r].img_val + 4 * ((2*rr-3)*(2*rr-3) + (2*cc-3)*(2*cc-3))
                                  + 2 * rr + cc + k / 16);
            end else begin
                img_v[k] = rand_pix(rows[r].fill);
            end
        end
        for (int t = 0; t < 27; t++) begin
            ker_v[t] = (rows[r].fill > FILL_RAMP) ? rand_pix(rows[r].fill) : rows[r].ker_val;
        end
        w_v = '{rows[r].w.w0, rows[r].w.w1, rows[r].w.w2, rows[r].w.w3};
        if (rows[r].fill > FILL_RAMP) begin
            for (int i = 0; i < 4; i++) begin
                w_v[i] = rand_pix(rows[r].fill);
            end
        end
    endtask

    task automatic compute_expected(input int r);
        int     sum;
        int     rr;
        int     cc;
        int     cmap [16];
        int     m [4];
        longint fc [4];
        for (int p = 0; p < 16; p++) begin
            sum = 0;
            for (int ch = 0; ch < N_CH; ch++) begin
                for (int t = 0; t < 9; t++) begin
                    rr = p / 4 + t / 3 - 1;
                    cc = p % 4 + t % 3 - 1;
                    if (rows[r].opt || (rr >= 0 && rr < 4 && cc >= 0 && cc < 4)) begin
                        rr = (rr < 0) ? 0 : ((rr > 3) ? 3 : rr);
                        cc = (cc < 0) ? 0 : ((cc > 3) ? 3 : cc);
                        sum += int'(img_v[ch * 16 + rr * 4 + cc]) * int'(ker_v[ch * 9 + t]);
                    end
                end
            end
            cmap[p] = sum;
        end
        // each 2x2 window of the map pools to one value
        for (int qr = 0; qr < 2; qr++) begin
            for (int qc = 0; qc < 2; qc++) begin
                m[qr * 2 + qc] = cmap[qr * 8 + qc * 2];
                for (int d = 1; d < 4; d++) begin
                    rr = qr * 2 + d / 2;
                    cc = qc * 2 + d % 2;
                    if (cmap[rr * 4 + cc] > m[qr * 2 + qc]) begin
                        m[qr * 2 + qc] = cmap[rr * 4 + cc];
                    end
                end
            end
        end
        fc[0] = longint'(m[0]) * w_v[0] + longint'(m[1]) * w_v[2];
        fc[1] = longint'(m[0]) * w_v[1] + longint'(m[1]) * w_v[3];
        fc[2] = longint'(m[2]) * w_v[0] + longint'(m[3]) * w_v[2];
        fc[3] = longint'(m[2]) * w_v[1] + longint'(m[3]) * w_v[3];
        for (int i = 0; i < 4; i++) begin
            rows[r].exp_res[i] = OUT_W'(fc[i]);
        end
    endtask

    // 48 beats on consecutive cycles with the checker armed on beat 0
    task automatic drive_frame(input int r);
        in_beat_t b;
        for (int k = 0; k < N_BEATS; k++) begin
            b.img    = img_v[k];
            b.kernel = (k < 27) ? ker_v[k] : '0;
            b.weight = (k < 4) ? w_v[k] : '0;
            b.opt    = (k == 0) ? rows[r].opt : 1'b0;
            @(posedge clk);
            in_valid <= 1'b1;
            in_beat  <= b;
            arm      <= (k == 0);
            if (k == 0) begin
                test_id  <= r;
                exp_vals <= rows[r].exp_res;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_beat  <= '0;
        arm      <= 1'b0;
    endtask

    // ==================================================
    // test sequence
    // ==================================================

    initial begin
        in_valid   = 1'b0;
        in_beat    = '0;
        arm        = 1'b0;
        test_id    = 0;
        exp_vals   = '0;
        lfsr_state = 32'hae2f3bb6;
        timed_out  = 1'b0;

        // corner, edge and interior sums differ under zero padding
        rows[0] = '{1'b0, FILL_CONST, 8'sd5, 8'sd1, {8'sd1, 8'sd2, 8'sd3, 8'sd4}, '0};
        // negative pixels so the corner wins the pool
        rows[1] = '{1'b0, FILL_CONST, -8'sd2, 8'sd1, {8'sd1, 8'sd2, 8'sd3, 8'sd4}, '0};
        rows[2] = '{1'b1, FILL_CONST, -8'sd2, 8'sd1, {8'sd1, 8'sd2, 8'sd3, 8'sd4}, '0};
        // fc0 and fc2 expose m0 and m2
        rows[3] = '{1'b1, FILL_RAMP, -8'sd40, 8'sd1, {8'sd1, 8'sd0, 8'sd0, 8'sd0}, '0};
        rows[4] = '{1'b0, FILL_RAMP, -8'sd40, 8'sd2, {8'sd3, -8'sd5, 8'sd7, -8'sd2}, '0};
        rows[5] = '{1'b1, FILL_LFSR, 8'sd0, 8'sd0, 32'd0, '0};
        rows[6] = '{1'b0, FILL_EXTREME, 8'sd0, 8'sd0, 32'd0, '0};
        rows[7] = '{1'b1, FILL_EXTREME, 8'sd0, 8'sd0, 32'd0, '0};
        rows[8] = '{1'b0, FILL_LFSR, 8'sd0, 8'sd0, 32'd0, '0};

        cyc = 0;
        while (rst_n !== 1'b1 && cyc < 20) begin
            @(posedge clk);
            cyc++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            timed_out = 1'b1;
        end

        // next frame starts only after the fourth result of the previous one
        for (int r = 0; r < N_ROWS && !timed_out; r++) begin
            build_frame(r);
            compute_expected(r);
            drive_frame(r);
            cyc = 0;
            while (n_done < r + 1 && cyc < TIMEOUT) begin
                @(posedge clk);
                cyc++;
            end
            if (n_done < r + 1) begin
                $display("test %0d: timed out waiting for 4 results on out_valid", r);
                timed_out = 1'b1;
            end
        end

        // quiet period to catch a late out_valid
        repeat (20) @(posedge clk);
        $display("tests completed %0d of %0d, errors %0d", n_done, N_ROWS, n_err);
        if (timed_out || n_err != 0 || n_done != N_ROWS) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

endmodule
